/* src/bt_hdr_pkg.sv */
package bt_hdr_pkg;

  typedef logic [3:0] pk_type_t;

  // bit 0 (lt_addr[0]) goes on air first
  typedef struct packed {
    logic       seqn;
    logic       arqn;
    logic       flow;
    pk_type_t   pk_type;
    logic [2:0] lt_addr;
  } hdr_fields_t;

  typedef union packed {
    hdr_fields_t fields;
    logic [9:0]  bits;
  } hdr_word_u;

  // access code
  localparam int PREAMBLE_BITS = 4;
  localparam int SYNC_BITS     = 64;
  localparam int TRAILER_BITS  = 4;

  // header, hec, fec 1/3
  localparam int HDR_BITS = 10;
  localparam int HEC_BITS = 8;
  localparam int FEC_REP  = 3;

  localparam int CODED_BITS     = (HDR_BITS + HEC_BITS) * FEC_REP;
  localparam int TX_PACKET_BITS = PREAMBLE_BITS + SYNC_BITS + TRAILER_BITS + CODED_BITS;

  // D8+D7+D5+D2+D+1, D8 implied
  localparam logic [7:0] HEC_POLY = 8'hA7;
  // D7+D4+1, D7 implied
  localparam logic [6:0] WHITEN_POLY = 7'h11;

endpackage

/* src/hec_lfsr.sv */
`timescale 1ns/1ps

module hec_lfsr (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            init_p,
  input  logic                            shift_p,
  input  logic                            bit_in,
  input  logic [bt_hdr_pkg::HEC_BITS-1:0] seed,
  output logic [bt_hdr_pkg::HEC_BITS-1:0] state
);
  import bt_hdr_pkg::*;

  logic fb;

  // feeding back the top stage itself shifts the remainder out
  assign fb = bit_in ^ state[HEC_BITS-1];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= '0;
    else if (init_p)
      state <= seed;                 // uap, lsb in stage 0
    else if (shift_p)
      state <= {state[HEC_BITS-2:0], 1'b0} ^ ({HEC_BITS{fb}} & HEC_POLY);
  end

endmodule

/* src/whiten_lfsr.sv */
`timescale 1ns/1ps

module whiten_lfsr (
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       init_p,
  input  logic       shift_p,
  input  logic [5:0] seed,
  output logic [6:0] state,
  output logic       out_bit
);
  import bt_hdr_pkg::*;

  assign out_bit = state[6];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= '0;
    else if (init_p)
      state <= {1'b1, seed};         // clk bits 6..1 below a forced one
    else if (shift_p)
      state <= {state[5:0], 1'b0} ^ ({7{state[6]}} & WHITEN_POLY);
  end

endmodule

/* src/header_pro.sv */
`timescale 1ns/1ps

module header_pro (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            p_1us,
  input  logic                            hdr_start_p,
  input  logic                            coding_en,
  input  logic                            fec_inc_p,
  input  logic                            dir_tx,
  input  logic                            hdr_bit_in,
  input  logic                            rx_bit,
  input  logic [bt_hdr_pkg::HEC_BITS-1:0] uap,
  input  logic [5:0]                      clk_bits,
  input  logic                            whiten_en,
  output logic                            coded_bit,
  output logic                            dec_bit,
  output logic                            hec_rem_zero
);
  import bt_hdr_pkg::*;

  logic [HEC_BITS-1:0] hec_state;
  logic                wht_bit;
  logic [4:0]          info_cnt;
  logic                in_hec;
  logic                info_bit;
  logic                mask;
  logic [1:0]          ones;
  logic [1:0]          votes;
  logic                hec_in;

  // hec word bit 0 is the register top stage, so it leaves lsb first
  assign in_hec   = info_cnt >= 5'(HDR_BITS);
  assign info_bit = in_hec ? hec_state[HEC_BITS-1] : hdr_bit_in;
  assign mask     = whiten_en & wht_bit;
  assign coded_bit = info_bit ^ mask;     // held for the whole triple

  // third sample arrives live on rx_bit
  assign votes   = ones + {1'b0, rx_bit};
  assign dec_bit = votes[1] ^ mask;       // 2 of 3
  assign hec_in  = dir_tx ? info_bit : dec_bit;

  assign hec_rem_zero = (hec_state == '0);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      ones <= '0;
    else if (fec_inc_p)
      ones <= '0;
    else if (coding_en && p_1us)
      ones <= votes;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      info_cnt <= '0;
    else if (hdr_start_p)
      info_cnt <= '0;
    else if (fec_inc_p)
      info_cnt <= info_cnt + 5'd1;
  end

  hec_lfsr u_hec (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .init_p  (hdr_start_p),
    .shift_p (fec_inc_p),
    .bit_in  (hec_in),
    .seed    (uap),
    .state   (hec_state)
  );

  whiten_lfsr u_whiten (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .init_p  (hdr_start_p),
    .shift_p (fec_inc_p),
    .seed    (clk_bits),
    .state   (),
    .out_bit (wht_bit)
  );

  assert property (@(posedge clk_6M) disable iff (!rstz) fec_inc_p |-> coding_en);

endmodule

/* src/header_bitp.sv */
`timescale 1ns/1ps

module header_bitp (
  input  logic                             clk_6M,
  input  logic                             rstz,
  input  logic                             p_1us,
  input  logic                             tx_valid,
  input  logic [bt_hdr_pkg::HDR_BITS-1:0]  tx_header,
  input  logic [bt_hdr_pkg::SYNC_BITS-1:0] sync_word,
  input  logic [bt_hdr_pkg::HEC_BITS-1:0]  uap,
  input  logic [5:0]                       clk_bits,
  input  logic                             whiten_en,
  input  logic                             rx_start,
  input  logic                             rx_bit,
  input  logic [2:0]                       my_lt_addr,
  output logic                             tx_ready,
  output logic                             tx_bit,
  output logic                             tx_done,
  output logic                             rx_done,
  output logic                             hec_good,
  output logic                             lt_addressed,
  output logic [bt_hdr_pkg::HDR_BITS-1:0]  dec_header
);
  import bt_hdr_pkg::*;

  localparam logic [6:0] PRE_LEN    = 7'(PREAMBLE_BITS);
  localparam logic [6:0] TRL_START  = 7'(PREAMBLE_BITS + SYNC_BITS);
  localparam logic [6:0] CODE_START = 7'(PREAMBLE_BITS + SYNC_BITS + TRAILER_BITS);
  localparam logic [6:0] TX_LAST    = 7'(TX_PACKET_BITS - 1);
  localparam logic [6:0] RX_END     = 7'(TX_PACKET_BITS);

  logic       busy;
  logic       dir_tx;
  logic       tx_pend;
  logic [6:0] bit_cnt;
  logic [1:0] rep_cnt;
  logic [4:0] hdr_idx;
  hdr_word_u  tx_req;
  hdr_word_u  rx_hdr;
  logic       tx_go;
  logic       rx_go;
  logic       end_p;
  logic       coding_en;
  logic       hdr_start_p;
  logic       fec_inc_p;
  logic       hdr_bit_in;
  logic [5:0] sync_idx;
  logic       air_bit;
  logic       coded_bit;
  logic       dec_bit;
  logic       hec_rem_zero;

  assign tx_ready = ~(busy | tx_pend);
  assign tx_go    = p_1us & tx_pend;
  assign rx_go    = p_1us & rx_start & ~busy & ~tx_pend;   // this tick is coded bit 0
  assign end_p    = busy & p_1us & (bit_cnt == (dir_tx ? TX_LAST : RX_END));

  assign coding_en   = (busy & (bit_cnt >= CODE_START) & (bit_cnt <= TX_LAST)) | rx_go;
  assign hdr_start_p = (busy & dir_tx & p_1us & (bit_cnt == CODE_START - 7'd1)) | rx_go;
  assign fec_inc_p   = coding_en & p_1us & (rep_cnt == 2'(FEC_REP - 1));

  assign hdr_bit_in = (hdr_idx < 5'(HDR_BITS)) ? tx_req.bits[hdr_idx[3:0]] : 1'b0;
  assign sync_idx   = bit_cnt[5:0] - 6'(PREAMBLE_BITS);

  always_comb
  begin
    if (bit_cnt < PRE_LEN)
      air_bit = sync_word[0] ^ bit_cnt[0];                 // ends opposite to sync bit 0
    else if (bit_cnt < TRL_START)
      air_bit = sync_word[sync_idx];
    else if (bit_cnt < CODE_START)
      air_bit = ~sync_word[SYNC_BITS-1] ^ bit_cnt[0];
    else
      air_bit = coded_bit;
  end

  assign tx_bit = busy & dir_tx & air_bit;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      busy    <= 1'b0;
      dir_tx  <= 1'b0;
      tx_pend <= 1'b0;
      bit_cnt <= '0;
    end
    else
    begin
      if (tx_valid && tx_ready)
        tx_pend <= 1'b1;
      else if (tx_go)
        tx_pend <= 1'b0;

      if (tx_go)
      begin
        busy    <= 1'b1;
        dir_tx  <= 1'b1;
        bit_cnt <= '0;
      end
      else if (rx_go)
      begin
        busy    <= 1'b1;
        dir_tx  <= 1'b0;
        bit_cnt <= CODE_START + 7'd1;  // sample 0 taken on this tick
      end
      else if (end_p)
        busy <= 1'b0;
      else if (busy && p_1us)
        bit_cnt <= bit_cnt + 7'd1;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (tx_valid && tx_ready)
      tx_req.bits <= tx_header;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rep_cnt <= '0;
    else if (!coding_en)
      rep_cnt <= '0;
    else if (p_1us)
      rep_cnt <= fec_inc_p ? 2'd0 : rep_cnt + 2'd1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hdr_idx <= '0;
    else if (hdr_start_p)
      hdr_idx <= '0;
    else if (fec_inc_p)
      hdr_idx <= hdr_idx + 5'd1;
  end

  // received header, bit 0 first
  always_ff @(posedge clk_6M)
  begin
    if (fec_inc_p && !dir_tx && hdr_idx < 5'(HDR_BITS))
      rx_hdr.bits <= {dec_bit, rx_hdr.bits[HDR_BITS-1:1]};
    if (end_p && !dir_tx)
      dec_header <= rx_hdr.bits;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_done      <= 1'b0;
      rx_done      <= 1'b0;
      hec_good     <= 1'b0;
      lt_addressed <= 1'b0;
    end
    else
    begin
      tx_done <= end_p & dir_tx;
      rx_done <= end_p & ~dir_tx;
      if (end_p && !dir_tx)
      begin
        hec_good     <= hec_rem_zero;
        lt_addressed <= hec_rem_zero && (rx_hdr.fields.lt_addr == my_lt_addr);
      end
    end
  end

  header_pro u_pro (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .p_1us        (p_1us),
    .hdr_start_p  (hdr_start_p),
    .coding_en    (coding_en),
    .fec_inc_p    (fec_inc_p),
    .dir_tx       (dir_tx),
    .hdr_bit_in   (hdr_bit_in),
    .rx_bit       (rx_bit),
    .uap          (uap),
    .clk_bits     (clk_bits),
    .whiten_en    (whiten_en),
    .coded_bit    (coded_bit),
    .dec_bit      (dec_bit),
    .hec_rem_zero (hec_rem_zero)
  );

  // ready only comes back as a packet ends
  assert property (@(posedge clk_6M) disable iff (!rstz)
                   $rose(tx_ready) |-> (tx_done || rx_done));
  // every packet closes on a whole triple
  assert property (@(posedge clk_6M) disable iff (!rstz)
                   end_p |-> (dir_tx ? fec_inc_p : (rep_cnt == 2'd0)));

endmodule

/* src/bt_header_top.sv */
`timescale 1ns/1ps

module bt_header_top (
  input  logic                             clk_6M,
  input  logic                             rstz,
  input  logic                             p_1us,
  input  logic [bt_hdr_pkg::SYNC_BITS-1:0] sync_word,
  input  logic [bt_hdr_pkg::HEC_BITS-1:0]  uap,
  input  logic [5:0]                       clk_bits,
  input  logic                             whiten_en,
  input  logic                             tx_valid,
  output logic                             tx_ready,
  input  logic [bt_hdr_pkg::HDR_BITS-1:0]  tx_header,
  output logic                             tx_bit,
  output logic                             tx_done,
  input  logic                             rx_start,
  input  logic                             rx_bit,
  input  logic [2:0]                       my_lt_addr,
  output logic                             rx_done,
  output logic                             hec_good,
  output logic                             lt_addressed,
  output logic [bt_hdr_pkg::HDR_BITS-1:0]  dec_header
);

  header_bitp u_bitp (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .p_1us        (p_1us),
    .tx_valid     (tx_valid),
    .tx_header    (tx_header),
    .sync_word    (sync_word),
    .uap          (uap),
    .clk_bits     (clk_bits),
    .whiten_en    (whiten_en),
    .rx_start     (rx_start),
    .rx_bit       (rx_bit),
    .my_lt_addr   (my_lt_addr),
    .tx_ready     (tx_ready),
    .tx_bit       (tx_bit),
    .tx_done      (tx_done),
    .rx_done      (rx_done),
    .hec_good     (hec_good),
    .lt_addressed (lt_addressed),
    .dec_header   (dec_header)
  );

endmodule

/* tb/hdr_model.svh */
`ifndef HDR_MODEL_SVH
`define HDR_MODEL_SVH

// hec bits in air order, bit 0 sent first
function automatic logic [7:0] hec_air(logic [9:0] hdr, logic [7:0] seed);
  logic [7:0] r;
  logic [7:0] hec;
  logic       fb;
  r = seed;
  for (int i = 0; i < HDR_BITS; i++)
  begin
    fb = hdr[i] ^ r[7];
    r  = {r[6:0], 1'b0} ^ (fb ? HEC_POLY : 8'h00);
  end
  for (int i = 0; i < HEC_BITS; i++)
    hec[i] = r[7-i];  // msb of the remainder leaves first
  return hec;
endfunction

// one mask bit per info bit
function automatic logic [17:0] whiten_seq(logic [5:0] clk);
  logic [6:0]  s;
  logic [17:0] m;
  s = {1'b1, clk};
  for (int i = 0; i < 18; i++)
  begin
    m[i] = s[6];
    s    = {s[5:0], 1'b0} ^ (s[6] ? WHITEN_POLY : 7'h00);
  end
  return m;
endfunction

function automatic logic [53:0] coded_stream(logic [9:0] hdr, logic [7:0] seed,
                                             logic [5:0] clk, logic wen);
  logic [17:0] info;
  logic [17:0] mask;
  logic [53:0] c;
  info = {hec_air(hdr, seed), hdr};
  mask = wen ? whiten_seq(clk) : 18'h0;
  for (int j = 0; j < 18; j++)
    for (int r = 0; r < FEC_REP; r++)
      c[FEC_REP*j + r] = info[j] ^ mask[j];
  return c;
endfunction

function automatic logic [71:0] access_code(logic [63:0] sw);
  logic [71:0] a;
  for (int k = 0; k < 4; k++)
    a[k] = (k % 2 == 0) ? sw[0] : ~sw[0];      // ends opposite to sw[0]
  for (int k = 0; k < 64; k++)
    a[4+k] = sw[k];
  for (int k = 0; k < 4; k++)
    a[68+k] = (k % 2 == 0) ? ~sw[63] : sw[63];
  return a;
endfunction

`endif

/* tb/tb_bt_header.sv */
`timescale 1ns/1ps

module tb_bt_header;
  import bt_hdr_pkg::*;

  `include "hdr_model.svh"

  localparam int TIMEOUT_CYCLES = 20 * 130 * 6 * 2;
  localparam int ROUNDS = 5;

  logic        clk_6M;
  logic        rstz;
  logic        p_1us;
  logic [63:0] sync_word;
  logic [7:0]  uap;
  logic [5:0]  clk_bits;
  logic        whiten_en;
  logic        tx_valid;
  logic        tx_ready;
  logic [9:0]  tx_header;
  logic        tx_bit;
  logic        tx_done;
  logic        rx_start;
  logic        rx_bit;
  logic [2:0]  my_lt_addr;
  logic        rx_done;
  logic        hec_good;
  logic        lt_addressed;
  logic [9:0]  dec_header;

  logic [2:0]   div_cnt;
  int           cycles;
  logic [125:0] tx_hist;   // bit k of the last packet at index k
  int           done_cnt;
  int           errs [1:6];
  int           checks;

  bt_header_top DUT (.*);

  initial
  begin
    clk_6M = 1'b0;
    forever #2 clk_6M = ~clk_6M;
  end

  always @(posedge clk_6M)
  begin
    div_cnt <= (div_cnt == 3'd5) ? 3'd0 : div_cnt + 3'd1;
    p_1us   <= (div_cnt == 3'd5);
    cycles  <= cycles + 1;
  end

  always @(negedge clk_6M)
  begin
    if (p_1us)
      tx_hist <= {tx_bit, tx_hist[125:1]};
    if (tx_done)
      done_cnt <= done_cnt + 1;
  end

  initial
  begin
    while (cycles < TIMEOUT_CYCLES)
      @(posedge clk_6M);
    $display("the run timed out after %0d cycles", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_bit(logic got, logic exp, int t, string msg);
    checks++;
    if (got !== exp)
    begin
      errs[t]++;
      $display("FAIL %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_header(hdr_word_u got, hdr_word_u exp, int t, string msg);
    checks++;
    if (got.bits !== exp.bits)
    begin
      errs[t]++;
      $display("FAIL %0t: %s got %h (lt_addr %0d) expected %h (lt_addr %0d)", $time, msg,
               got.bits, got.fields.lt_addr, exp.bits, exp.fields.lt_addr);
    end
  endtask

  task automatic check_flag(logic got, logic exp, int t, string msg);
    checks++;
    if (got !== exp)
    begin
      errs[t]++;
      $display("FAIL %0t: %s flag %b expected %b", $time, msg, got, exp);
    end
  endtask

  // returns on the edge that raises p_1us
  task automatic next_tick();
    @(posedge clk_6M);
    while (div_cnt != 3'd5)
      @(posedge clk_6M);
  endtask

  task automatic send_request(logic [9:0] hdr);
    @(posedge clk_6M);
    tx_valid  <= 1'b1;
    tx_header <= hdr;
    @(posedge clk_6M);
    while (!tx_ready)
      @(posedge clk_6M);
    tx_valid <= 1'b0;
  endtask

  task automatic wait_tx_done();
    @(negedge clk_6M);
    while (!tx_done)
      @(negedge clk_6M);
  endtask

  task automatic replay(logic [53:0] coded, logic [53:0] flips);
    for (int i = 0; i < CODED_BITS; i++)
    begin
      next_tick();
      rx_bit   <= coded[i] ^ flips[i];
      rx_start <= (i == 0);
    end
    next_tick();
    rx_bit <= 1'b0;
    @(negedge clk_6M);
    while (!rx_done)
      @(negedge clk_6M);
  endtask

  task automatic check_decode(hdr_word_u exp, logic good, logic addr, int t, string tag);
    hdr_word_u got;
    got.bits = dec_header;
    check_header(got, exp, t, {tag, " dec_header"});
    check_flag(hec_good, good, t, {tag, " hec_good"});
    check_flag(lt_addressed, addr, t, {tag, " lt_addressed"});
  endtask

  task automatic report(int t, string name);
    $display("test %0d %s: %s (%0d errors)", t, name, (errs[t] == 0) ? "ok" : "bad", errs[t]);
  endtask

  initial
  begin
    hdr_word_u   hdr;
    hdr_word_u   hdr_b;
    hdr_word_u   exp;
    logic [31:0] rnd;
    logic [71:0] exp_ac;
    logic [53:0] exp_cd;
    logic [53:0] air;
    logic [53:0] flips;
    logic [2:0]  my_addr;
    int          t;
    int          p;
    int          base;

    rstz = 1'b0;
    p_1us = 1'b0;
    div_cnt = 3'd0;
    cycles = 0;
    sync_word = '0;
    uap = '0;
    clk_bits = '0;
    whiten_en = 1'b0;
    tx_valid = 1'b0;
    tx_header = '0;
    rx_start = 1'b0;
    rx_bit = 1'b0;
    my_lt_addr = '0;
    tx_hist = '0;
    done_cnt = 0;
    checks = 0;
    for (int i = 1; i <= 6; i++)
      errs[i] = 0;
    rnd = $urandom(32'ha9ee017d);

    repeat (4) @(posedge clk_6M);
    rstz <= 1'b1;
    @(negedge clk_6M);
    check_flag(tx_ready, 1'b1, 1, "reset tx_ready");
    check_flag(tx_done, 1'b0, 1, "reset tx_done");
    check_flag(rx_done, 1'b0, 1, "reset rx_done");
    check_flag(hec_good, 1'b0, 1, "reset hec_good");
    check_flag(lt_addressed, 1'b0, 1, "reset lt_addressed");
    check_bit(tx_bit, 1'b0, 1, "reset tx_bit");
    report(1, "reset values");

    for (int r = 0; r < ROUNDS; r++)
    begin
      rnd = $urandom;
      hdr.bits = rnd[9:0];
      my_addr = (r % 2 == 0) ? hdr.fields.lt_addr : rnd[12:10];
      @(posedge clk_6M);
      sync_word  <= {$urandom, $urandom};
      uap        <= rnd[20:13];
      clk_bits   <= rnd[26:21];
      whiten_en  <= (r % 2 == 1);
      my_lt_addr <= my_addr;
      @(posedge clk_6M);
      send_request(hdr.bits);
      wait_tx_done();

      exp_ac = access_code(sync_word);
      exp_cd = coded_stream(hdr.bits, uap, clk_bits, whiten_en);
      for (int k = 0; k < 72; k++)
        check_bit(tx_hist[k], exp_ac[k], 2, $sformatf("round %0d access bit %0d", r, k));
      for (int k = 0; k < CODED_BITS; k++)
        check_bit(tx_hist[72+k], exp_cd[k], 3, $sformatf("round %0d coded bit %0d", r, k));
      air = tx_hist[125:72];

      replay(air, '0);
      check_decode(hdr, 1'b1, hdr.fields.lt_addr == my_addr, 4, "clean");

      // triple 0 always hit, others at random
      flips = '0;
      for (int j = 0; j < 18; j++)
        if (j == 0 || $urandom % 2 == 1)
          flips[3*j + int'($urandom % 3)] = 1'b1;
      replay(air, flips);
      check_decode(hdr, 1'b1, hdr.fields.lt_addr == my_addr, 5, "single flips");

      t = int'($urandom % 18);
      p = int'($urandom % 3);
      flips = '0;
      flips[3*t + p] = 1'b1;
      flips[3*t + (p + 1) % 3] = 1'b1;
      exp = hdr;
      if (t < HDR_BITS)
        exp.bits[t] = ~exp.bits[t];
      replay(air, flips);
      check_decode(exp, 1'b0, 1'b0, 5, $sformatf("double flip triple %0d", t));
    end
    report(2, "access code");
    report(3, "coded header");
    report(4, "clean loopback");
    report(5, "fec correction");

    rnd = $urandom;
    hdr.bits = rnd[9:0];
    hdr_b.bits = rnd[19:10];
    send_request(hdr.bits);
    repeat (20) next_tick();
    base = done_cnt;
    @(posedge clk_6M);
    tx_valid  <= 1'b1;
    tx_header <= hdr_b.bits;
    @(posedge clk_6M);
    while (!tx_ready)
      @(posedge clk_6M);
    tx_valid <= 1'b0;
    check_flag(done_cnt == base + 1, 1'b1, 6, "accepted only after tx_done");
    wait_tx_done();
    exp_cd = coded_stream(hdr_b.bits, uap, clk_bits, whiten_en);
    for (int k = 0; k < CODED_BITS; k++)
      check_bit(tx_hist[72+k], exp_cd[k], 6, $sformatf("held request coded bit %0d", k));
    repeat (140) next_tick();
    @(negedge clk_6M);
    check_flag(done_cnt == base + 2, 1'b1, 6, "exactly one further packet");
    check_flag(tx_ready, 1'b1, 6, "idle tx_ready");
    report(6, "held tx_valid");

    $display("%0d checks, %0d errors", checks,
             errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6]);
    if (errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6] == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* project.f */
+incdir+tb
src/bt_hdr_pkg.sv
src/hec_lfsr.sv
src/whiten_lfsr.sv
src/header_pro.sv
src/header_bitp.sv
src/bt_header_top.sv
tb/tb_bt_header.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bt_header
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
